//--- common/tetris_score_pkg.sv
`default_nettype none

package tetris_score_pkg;

  // ==========================================================================
  // Event and pipeline types
  // ==========================================================================

  typedef enum logic [2:0] {
    SPIN_NONE   = 3'd0,
    SPIN_T      = 3'd1,
    SPIN_T_MINI = 3'd2,
    SPIN_SZ     = 3'd3,
    SPIN_JL     = 3'd4,
    SPIN_I      = 3'd5
  } spin_kind_t;

  typedef struct packed {
    logic       valid;  // One-cycle strobe
    logic [2:0] lines;  // 0 to 4 when legal
    spin_kind_t spin;
  } lock_event_t;

  typedef struct packed {
    logic       valid;
    logic [2:0] lines;
    spin_kind_t spin;
    logic [3:0] streak; // Value before this event
    logic [3:0] level;  // Value before this event
  } award_job_t;

  typedef struct packed {
    logic            valid;
    logic [4:0][3:0] digits; // Digit 0 is the ones place
  } bcd_award_t;

  // Score word, flat for the port or as eight decimal digits
  typedef union packed {
    logic [31:0]     word;
    logic [7:0][3:0] digits;
  } score_u;

  // ==========================================================================
  // Game rules
  // ==========================================================================

  localparam logic [2:0] MAX_LINES       = 3'd4;
  localparam logic [3:0] MAX_LEVEL       = 4'd15;
  localparam logic [7:0] LINES_PER_LEVEL = 8'd10;
  localparam logic [3:0] STREAK_CAP      = 4'd5;
  localparam logic [9:0] STREAK_STEP     = 10'd100;

  // NES style base score, indexed by lines cleared
  localparam logic [10:0] BASE_POINTS [0:4] = '{
    11'd0, 11'd40, 11'd100, 11'd300, 11'd1200
  };

  // Spin score, indexed by spin kind then lines cleared
  localparam logic [10:0] SPIN_POINTS [0:5][0:4] = '{
    '{11'd0,   11'd0,   11'd0,    11'd0,    11'd0},    // None
    '{11'd400, 11'd800, 11'd1200, 11'd1600, 11'd0},    // T
    '{11'd100, 11'd200, 11'd0,    11'd0,    11'd0},    // T mini
    '{11'd0,   11'd400, 11'd800,  11'd1200, 11'd0},    // S or Z
    '{11'd0,   11'd400, 11'd800,  11'd1200, 11'd0},    // J or L
    '{11'd0,   11'd400, 11'd800,  11'd0,    11'd1600}  // I
  };

  // Game ticks per gravity step, by level
  localparam logic [5:0] DROP_FRAMES [0:15] = '{
    6'd40, 6'd37, 6'd34, 6'd30, 6'd26, 6'd21, 6'd15, 6'd12,
    6'd8,  6'd6,  6'd5,  6'd5,  6'd5,  6'd4,  6'd3,  6'd2
  };

endpackage

`default_nettype wire

//--- scoring/bin_to_bcd.sv
`timescale 1ns/10ps
`default_nettype none

module bin_to_bcd #(
  parameter int AWARD_WIDTH  = 16,
  parameter int AWARD_DIGITS = 5
) (
  input  logic [AWARD_WIDTH-1:0]    binary,
  output logic [AWARD_DIGITS*4-1:0] bcd
);

  localparam int SHIFT_WIDTH = AWARD_WIDTH + AWARD_DIGITS * 4;

  logic [SHIFT_WIDTH-1:0] shift;

  // Double dabble, one pass per input bit
  always_comb begin
    shift                    = '0;
    shift[AWARD_WIDTH-1:0]   = binary;

    for (int i = 0; i < AWARD_WIDTH; i++) begin
      // Correct any digit of 5 or more before it doubles
      for (int d = 0; d < AWARD_DIGITS; d++) begin
        if (shift[AWARD_WIDTH + 4*d +: 4] >= 4'd5) begin
          shift[AWARD_WIDTH + 4*d +: 4] = shift[AWARD_WIDTH + 4*d +: 4] + 4'd3;
        end
      end
      shift = shift << 1;
    end
  end

  assign bcd = shift[AWARD_WIDTH +: AWARD_DIGITS*4];  // Digits end up above the binary field

endmodule

`default_nettype wire

//--- scoring/points_calc.sv
`timescale 1ns/10ps
`default_nettype none

module points_calc #(
  parameter int AWARD_WIDTH  = 16,
  parameter int AWARD_DIGITS = 5
) (
  input  logic                         clk,
  input  logic                         rst,
  input  tetris_score_pkg::award_job_t award_job,
  output tetris_score_pkg::bcd_award_t bcd_award
);

  import tetris_score_pkg::*;

  logic [4:0]                  mult;         // 1 at level 0 up to 16
  logic [10:0]                 base_pts;
  logic [10:0]                 spin_pts;
  logic [3:0]                  streak_eff;
  logic [AWARD_WIDTH-1:0]      base_term;
  logic [AWARD_WIDTH-1:0]      streak_term;
  logic [AWARD_WIDTH-1:0]      spin_term;
  logic [AWARD_WIDTH-1:0]      points;
  logic [AWARD_DIGITS*4-1:0]   bcd_value;
  logic                        has_lines;

  assign has_lines = (award_job.lines != 3'd0);
  assign mult      = {1'b0, award_job.level} + 5'd1;

  // ==========================================================================
  // Point sum
  // ==========================================================================
  always_comb begin
    base_pts   = BASE_POINTS[award_job.lines];
    spin_pts   = SPIN_POINTS[award_job.spin][award_job.lines];
    streak_eff = (award_job.streak > STREAK_CAP) ? STREAK_CAP : award_job.streak;

    base_term = AWARD_WIDTH'(base_pts) * AWARD_WIDTH'(mult);
    spin_term = AWARD_WIDTH'(spin_pts) * AWARD_WIDTH'(mult);

    // Bonus only while a streak of clears is running
    if (has_lines && (award_job.streak != 4'd0)) begin
      streak_term = AWARD_WIDTH'(streak_eff) * AWARD_WIDTH'(STREAK_STEP);
    end else begin
      streak_term = '0;
    end

    points = base_term + streak_term + spin_term;
  end

  bin_to_bcd #(
    .AWARD_WIDTH  (AWARD_WIDTH),
    .AWARD_DIGITS (AWARD_DIGITS)
  ) bin_to_bcd_i (
    .binary (points),
    .bcd    (bcd_value)
  );

  // ==========================================================================
  // Award register
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      bcd_award.valid <= 1'b0;
    end else begin
      bcd_award.valid <= award_job.valid && has_lines; // No lines, no award
    end
    bcd_award.digits <= bcd_value;
  end

endmodule

`default_nettype wire

//--- hdl/line_tally.sv
`timescale 1ns/10ps
`default_nettype none

module line_tally (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          new_game,
  input  tetris_score_pkg::lock_event_t lock_event,
  output tetris_score_pkg::award_job_t  award_job,
  output logic [3:0]                    level,
  output logic [7:0]                    total_lines
);

  import tetris_score_pkg::*;

  logic [3:0] streak;
  logic [7:0] level_raw;
  logic [8:0] lines_sum;
  logic       accept;

  // Legal events only, and never on a new game cycle
  assign accept = lock_event.valid && (lock_event.lines <= MAX_LINES) && !new_game;

  assign lines_sum = {1'b0, total_lines} + {6'd0, lock_event.lines};

  // Level follows the line total directly
  assign level_raw = total_lines / LINES_PER_LEVEL;
  assign level     = (level_raw > {4'd0, MAX_LEVEL}) ? MAX_LEVEL : level_raw[3:0];

  // ==========================================================================
  // Totals and streak
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      total_lines <= '0;
      streak      <= '0;
    end else if (accept) begin
      total_lines <= lines_sum[8] ? 8'hff : lines_sum[7:0]; // Saturate at 255
      if (lock_event.lines == 3'd0) begin
        streak <= '0;           // Streak broken
      end else if (streak != 4'hf) begin
        streak <= streak + 4'd1;
      end
    end
  end

  // ==========================================================================
  // Award job, carries the state from before the event
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      award_job.valid <= 1'b0;
    end else begin
      award_job.valid <= accept;
    end
    award_job.lines  <= lock_event.lines;
    award_job.spin   <= lock_event.spin;
    award_job.streak <= streak;
    award_job.level  <= level;
  end

endmodule

`default_nettype wire

//--- hdl/bcd_score_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module bcd_score_accumulator (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         new_game,
  input  tetris_score_pkg::bcd_award_t bcd_award,
  output logic [31:0]                  score
);

  import tetris_score_pkg::*;

  score_u          acc;
  score_u          acc_next;
  logic [7:0][3:0] addend;   // Award padded out to eight digits

  assign addend = {12'd0, bcd_award.digits};

  // ==========================================================================
  // Decimal add with carry rippling through all digits
  // ==========================================================================
  always_comb begin
    logic       carry;
    logic [4:0] digit_sum;

    carry = 1'b0;
    for (int d = 0; d < 8; d++) begin
      digit_sum = {1'b0, acc.digits[d]} + {1'b0, addend[d]} + {4'd0, carry};
      if (digit_sum >= 5'd10) begin
        acc_next.digits[d] = 4'(digit_sum - 5'd10);
        carry              = 1'b1;
      end else begin
        acc_next.digits[d] = digit_sum[3:0];
        carry              = 1'b0;
      end
    end
    // Carry out of the top digit drops, score rolls over to zero
  end

  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      acc.word <= '0;
    end else if (bcd_award.valid) begin
      acc.word <= acc_next.word;
    end
  end

  assign score = acc.word;

endmodule

`default_nettype wire

//--- hdl/gravity_pacer.sv
`timescale 1ns/10ps
`default_nettype none

module gravity_pacer (
  input  logic       clk,
  input  logic       rst,
  input  logic       new_game,
  input  logic       tick_game,
  input  logic [3:0] level,
  output logic       gravity_step
);

  import tetris_score_pkg::*;

  logic [5:0] tick_count;
  logic [5:0] tick_limit;
  logic       period_done;

  assign tick_limit = DROP_FRAMES[level];

  // Greater-or-equal covers a level-up that shortens the interval mid count
  assign period_done = (tick_count + 6'd1) >= tick_limit;

  // ==========================================================================
  // Tick counter and step pulse
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      tick_count   <= '0;
      gravity_step <= 1'b0;
    end else if (tick_game) begin
      if (period_done) begin
        tick_count   <= '0;      // Restart the interval
        gravity_step <= 1'b1;
      end else begin
        tick_count   <= tick_count + 6'd1;
        gravity_step <= 1'b0;
      end
    end else begin
      gravity_step <= 1'b0;      // Single-cycle pulse
    end
  end

endmodule

`default_nettype wire

//--- hdl/tetris_score_top.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_score_top #(
  parameter int AWARD_WIDTH  = 16,
  parameter int AWARD_DIGITS = 5
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        new_game,
  input  logic                        tick_game,
  input  tetris_score_pkg::lock_event_t lock_event,
  output logic [31:0]                 score,
  output logic [3:0]                  level,
  output logic [7:0]                  total_lines,
  output logic                        gravity_step
);

  import tetris_score_pkg::*;

  award_job_t award_job;  // Tally to points, one cycle after the event
  bcd_award_t bcd_award;  // Points to score, two cycles after

  // ==========================================================================
  // Input side
  // ==========================================================================
  line_tally line_tally_i (
    .clk         (clk),
    .rst         (rst),
    .new_game    (new_game),
    .lock_event  (lock_event),
    .award_job   (award_job),
    .level       (level),
    .total_lines (total_lines)
  );

  // ==========================================================================
  // Processing
  // ==========================================================================
  points_calc #(
    .AWARD_WIDTH  (AWARD_WIDTH),
    .AWARD_DIGITS (AWARD_DIGITS)
  ) points_calc_i (
    .clk       (clk),
    .rst       (rst),
    .award_job (award_job),
    .bcd_award (bcd_award)
  );

  // ==========================================================================
  // Output side
  // ==========================================================================
  bcd_score_accumulator bcd_score_accumulator_i (
    .clk       (clk),
    .rst       (rst),
    .new_game  (new_game),
    .bcd_award (bcd_award),
    .score     (score)
  );

  gravity_pacer gravity_pacer_i (
    .clk          (clk),
    .rst          (rst),
    .new_game     (new_game),
    .tick_game    (tick_game),
    .level        (level),
    .gravity_step (gravity_step)
  );

endmodule

`default_nettype wire

//--- bench/tetris_score_tb_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_score_tb_assertions (
  input logic        clk,
  input logic        rst,
  input logic        new_game,
  input logic        lock_valid,
  input logic [31:0] score,
  input logic        gravity_step
);

  int failures;  // Read by the testbench at the end

  initial failures = 0;

  // ==========================================================================
  // Gravity pulse width
  // ==========================================================================
  property single_cycle_step;
    @(posedge clk) disable iff (rst)
      gravity_step |=> !gravity_step;
  endproperty

  assert property (single_cycle_step) else begin
    $error("gravity_step stayed high for two cycles");
    failures++;
  end

  // ==========================================================================
  // Score moves only on the award pipeline or a new game
  // ==========================================================================
  property score_change_cause;
    @(posedge clk) disable iff (rst)
      $changed(score) |-> ($past(lock_valid, 3) || $past(new_game));
  endproperty

  assert property (score_change_cause) else begin
    $error("score changed without a lock event or new game before it");
    failures++;
  end

endmodule

`default_nettype wire

//--- bench/tetris_score_tb.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_score_tb;

  import tetris_score_pkg::*;

  localparam int GRAVITY_LIMIT = 100;  // Ticks before a gravity wait gives up

  // Expected values taken from the game rules
  localparam int BASE_SCORE [5]  = '{0, 40, 100, 300, 1200};
  localparam int DROP_TICKS [16] = '{40, 37, 34, 30, 26, 21, 15, 12,
                                     8, 6, 5, 5, 5, 4, 3, 2};

  logic        clk;
  logic        rst;
  logic        new_game;
  logic        tick_game;
  lock_event_t lock_event;
  logic [31:0] score;
  logic [3:0]  level;
  logic [7:0]  total_lines;
  logic        gravity_step;

  // Stimulus table with one entry per row in each queue
  int row_lines[$];
  int row_spin[$];
  bit row_restart[$];
  bit row_gravity[$];
  int row_pre_ticks[$];

  int model_score;
  int model_total;
  int model_streak;
  int error_count;
  int tests_run;
  int tests_failed;
  bit timed_out;

  tetris_score_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .new_game     (new_game),
    .tick_game    (tick_game),
    .lock_event   (lock_event),
    .score        (score),
    .level        (level),
    .total_lines  (total_lines),
    .gravity_step (gravity_step)
  );

  bind tetris_score_top tetris_score_tb_assertions assertions_i (
    .clk          (clk),
    .rst          (rst),
    .new_game     (new_game),
    .lock_valid   (lock_event.valid),
    .score        (score),
    .gravity_step (gravity_step)
  );

  always #50 clk = ~clk;

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic int level_of(input int total);
    return (total / 10 > 15) ? 15 : total / 10;
  endfunction

  function automatic int spin_score_of(input int spin, input int lines);
    case (spin)
      SPIN_T:      return (lines <= 3) ? 400 * (lines + 1) : 0;
      SPIN_T_MINI: return (lines <= 1) ? 100 * (lines + 1) : 0;
      SPIN_SZ,
      SPIN_JL:     return (lines >= 1 && lines <= 3) ? 400 * lines : 0;
      SPIN_I:      return (lines == 4) ? 1600 : ((lines <= 2) ? 400 * lines : 0);
      default:     return 0;
    endcase
  endfunction

  function automatic int points_for(input int lines, input int spin, input int lvl,
                                    input int streak);
    int mult;
    int bonus;
    mult  = lvl + 1;
    bonus = (streak > 5) ? 500 : streak * 100;
    if (lines == 0) return 0;  // Spin alone earns nothing
    return BASE_SCORE[lines] * mult + bonus + spin_score_of(spin, lines) * mult;
  endfunction

  function automatic logic [31:0] bcd_of(input int value);
    logic [31:0] word;
    int          rest;
    rest = value;
    for (int d = 0; d < 8; d++) begin
      word[d*4 +: 4] = 4'(rest % 10);
      rest           = rest / 10;
    end
    return word;
  endfunction

  // ==========================================================================
  // Checks and stimulus helpers
  // ==========================================================================
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic add_row(input int lines, input int spin, input bit restart,
                         input bit gravity, input int pre_ticks);
    row_lines.push_back(lines);
    row_spin.push_back(spin);
    row_restart.push_back(restart);
    row_gravity.push_back(gravity);
    row_pre_ticks.push_back(pre_ticks);
  endtask

  task automatic send_tick();
    @(posedge clk);
    tick_game <= 1'b1;
    @(posedge clk);
    tick_game <= 1'b0;
  endtask

  // Ticks until the first gravity step from a zero count
  task automatic measure_gravity(output int ticks, output bit seen);
    seen  = 1'b0;
    ticks = 0;
    while (!seen && ticks < GRAVITY_LIMIT) begin
      send_tick();
      @(negedge clk);
      ticks++;
      seen = gravity_step;
    end
  endtask

  task automatic apply_row(input int i);
    int ticks;
    bit seen;
    for (int t = 0; t < row_pre_ticks[i]; t++) send_tick();
    @(posedge clk);
    lock_event.valid <= 1'b1;
    lock_event.lines <= 3'(row_lines[i]);
    lock_event.spin  <= spin_kind_t'(3'(row_spin[i]));
    new_game         <= row_restart[i];
    @(posedge clk);
    lock_event <= '0;
    new_game   <= 1'b0;
    repeat (2) @(posedge clk);  // Score lands three cycles after the event
    @(negedge clk);

    if (row_restart[i]) begin
      model_score  = 0;
      model_total  = 0;
      model_streak = 0;
    end else if (row_lines[i] <= 4) begin
      model_score = (model_score + points_for(row_lines[i], row_spin[i],
                     level_of(model_total), model_streak)) % 100000000;
      model_total = (model_total + row_lines[i] > 255) ? 255 : model_total + row_lines[i];
      if (row_lines[i] == 0) model_streak = 0;
      else if (model_streak < 15) model_streak++;
    end

    check_value("score", score, bcd_of(model_score));
    check_value("level", 32'(level), 32'(level_of(model_total)));
    check_value("total_lines", 32'(total_lines), 32'(model_total));
    if (row_gravity[i]) begin
      measure_gravity(ticks, seen);
      if (seen) begin
        check_value("gravity ticks", 32'(ticks), 32'(DROP_TICKS[level_of(model_total)]));
      end else begin
        $display("Timeout: no gravity step within %0d ticks", GRAVITY_LIMIT);
        error_count++;
        timed_out = 1'b1;
      end
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    int errors_before;
    clk          = 1'b0;
    rst          = 1'b1;
    new_game     = 1'b0;
    tick_game    = 1'b0;
    lock_event   = '0;
    model_score  = 0;
    model_total  = 0;
    model_streak = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    void'($urandom(32'h21d1));

    // Single clears then illegal line counts and gravity at level 1
    add_row(1, SPIN_NONE, 0, 0, 0);
    add_row(0, SPIN_NONE, 0, 0, 0);
    add_row(2, SPIN_NONE, 0, 0, 0);
    add_row(0, SPIN_NONE, 0, 0, 0);
    add_row(3, SPIN_NONE, 0, 0, 0);
    add_row(0, SPIN_NONE, 0, 0, 0);
    add_row(4, SPIN_NONE, 0, 0, 0);
    add_row(0, SPIN_NONE, 0, 0, 0);
    add_row(5, SPIN_NONE, 0, 0, 0);
    add_row(6, SPIN_T,    0, 0, 0);
    add_row(7, SPIN_NONE, 0, 1, 0);
    add_row(3, SPIN_NONE, 1, 1, 0);  // Restart drops its event
    // Streak past the cap and broken by a T spin with no lines
    for (int i = 0; i < 7; i++) add_row(1, SPIN_NONE, 0, 0, 0);
    add_row(0, SPIN_T,    0, 0, 0);
    add_row(2, SPIN_NONE, 0, 0, 0);
    for (int i = 0; i < 6; i++) add_row(i % 3 + 1, int'($urandom_range(5, 1)), 0, 0, 0);
    add_row(0, SPIN_NONE, 0, 1, 0);  // Level 2 by now
    add_row(4, SPIN_I,    0, 0, 0);
    add_row(2, SPIN_NONE, 1, 1, 7);  // Restart mid interval

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Nothing moves after reset without ticks
    @(negedge clk);
    check_value("score", score, 32'd0);
    check_value("level", 32'(level), 32'd0);
    check_value("total_lines", 32'(total_lines), 32'd0);
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      check_value("gravity_step", 32'(gravity_step), 32'd0);
    end
    tests_run++;
    if (error_count != 0) tests_failed++;
    $display("reset state: %s", (error_count != 0) ? "mismatch" : "ok");

    for (int i = 0; i < row_lines.size() && !timed_out; i++) begin
      errors_before = error_count;
      apply_row(i);
      tests_run++;
      if (error_count != errors_before) tests_failed++;
      $display("row %0d lines %0d spin %0d restart %0d: %s", i, row_lines[i],
               row_spin[i], row_restart[i], (error_count != errors_before) ? "mismatch" : "ok");
    end

    error_count += dut_i.assertions_i.failures;
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tetris_score.f
common/tetris_score_pkg.sv
scoring/bin_to_bcd.sv
scoring/points_calc.sv
hdl/line_tally.sv
hdl/bcd_score_accumulator.sv
hdl/gravity_pacer.sv
hdl/tetris_score_top.sv
bench/tetris_score_tb_assertions.sv
bench/tetris_score_tb.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tetris_score_tb
FILE_LIST := tetris_score.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILE_LIST))
PASS_TEXT := Everything OK

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
